// ==== filelist.f ====
verilog/pktgen_pkg.sv
verilog/pktgen_regs.sv
verilog/prbs23.sv
verilog/payload_src.sv
verilog/frame_fsm.sv
verilog/pktgen_top.sv
bench/tb_pktgen.sv

// ==== run.sh ====
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_pktgen -f filelist.f -o tb_pktgen
if [ $? -ne 0 ]; then
   echo "verilator build did not succeed"
   exit 1
fi

./obj_dir/tb_pktgen > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^test passed$" sim.log; then
   exit 0
fi
exit 1

// ==== bench/tb_pktgen.sv ====
// prbs payload is checked by its first beat and by comparing runs, and tx_ready is random from a fixed seed
module tb_pktgen;

   localparam int N_CFG      = 10;
   localparam int WAIT_LIMIT = 40000;  // cycles allowed per wait
   localparam int QUIET      = 100;    // idle window after a run

   logic                                  clk;
   logic                                  reset;
   logic [pktgen_pkg::ADDR_W-1:0]         address;
   logic                                  read;
   logic                                  write;
   logic [pktgen_pkg::DATA_W-1:0]         writedata;
   logic [pktgen_pkg::DATA_W-1:0]         readdata;
   logic                                  waitrequest;
   logic                                  tx_ready;
   logic [pktgen_pkg::BEAT_W-1:0]         tx_data;
   logic                                  tx_valid;
   logic                                  tx_sop;
   logic                                  tx_eop;
   logic [pktgen_pkg::EMPTY_W-1:0]        tx_empty;

   integer      seed = 32'hbc4c;
   logic [31:0] ready_rnd;
   int          err_cnt;
   int          timeout_cnt;

   // expected frame of the run in progress
   logic [47:0] exp_da;
   logic [47:0] exp_sa;
   logic [15:0] exp_len;
   logic        exp_rnd;
   logic [63:0] exp_first;    // first prbs beat of the run from the seeds
   int          beat_idx;     // beat position inside the frame
   int          frames_seen;  // whole frames in this run
   logic [63:0] rnd_q[$];     // random payload of this run
   logic [63:0] rnd_ref[$];   // reference random payload
   logic        stalled;      // valid without ready at the last sample
   logic [69:0] stall_beat;   // stream outputs at that sample

   // configuration table
   logic [47:0]        cfg_da   [N_CFG];
   logic [47:0]        cfg_sa   [N_CFG];
   logic [31:0]        cfg_len  [N_CFG];
   logic [31:0]        cfg_cnt  [N_CFG];  // 0 runs until stop
   logic               cfg_rnd  [N_CFG];
   logic [2:0][22:0]   cfg_seed [N_CFG];
   int                 cfg_cmp  [N_CFG];  // 1 keep ref, 2 same as ref, 3 differs

   pktgen_top u_dut (
      .clk(clk), .reset(reset), .address(address), .read(read), .write(write),
      .writedata(writedata), .readdata(readdata), .waitrequest(waitrequest),
      .tx_ready(tx_ready), .tx_data(tx_data), .tx_valid(tx_valid), .tx_sop(tx_sop),
      .tx_eop(tx_eop), .tx_empty(tx_empty)
   );

   initial clk = 1'b0;
   always #2 clk = ~clk;

   // random back-pressure with about 3 cycles in 4 ready
   initial begin
      tx_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         ready_rnd = $random(seed);
         tx_ready  = (ready_rnd[1:0] != 2'b00);
      end
   end

   task automatic report_mismatch(input string what, input logic [63:0] got,
                                  input logic [63:0] exp);
      $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
      err_cnt++;
   endtask

   task automatic abort_run(input string why);
      timeout_cnt++;
      $display("%s at time %0t", why, $time);
      $display("errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
      $display("test failed");
      $finish;
   endtask

   function automatic logic [15:0] clamp_len(input logic [31:0] raw);
      if (raw < 32'd8) return 16'd8;
      if (raw > 32'd1500) return 16'd1500;
      return raw[15:0];
   endfunction

   // ------------------------------
   // host port
   // ------------------------------
   // entered and left 1 unit after a rising edge with the strobes low for one cycle at the end
   task automatic reg_access(input logic is_wr, input logic [7:0] addr,
                             input logic [31:0] data, output logic [31:0] rdata);
      int   wait_hi;
      int   guard;
      logic low_seen;
      address   = addr;
      writedata = data;
      write     = is_wr;
      read      = ~is_wr;
      wait_hi   = 0;
      guard     = 0;
      low_seen  = 1'b0;
      while (!low_seen && guard < 20) begin
         @(negedge clk);  // mid cycle sample
         if (waitrequest) begin
            wait_hi++;
            @(posedge clk);
            #1;
         end else begin
            low_seen = 1'b1;
         end
         guard++;
      end
      if (!low_seen) abort_run("waitrequest never went low during a register access");
      if (wait_hi != 1) report_mismatch("waitrequest high cycles", 64'(wait_hi), 64'd1);
      rdata = readdata;
      @(posedge clk);
      #1;
      read  = 1'b0;
      write = 1'b0;
      @(posedge clk);  // idle cycle between accesses
      #1;
   endtask

   task automatic reg_write(input logic [7:0] addr, input logic [31:0] data);
      logic [31:0] ignored;
      reg_access(1'b1, addr, data, ignored);
   endtask

   task automatic reg_read(input logic [7:0] addr, output logic [31:0] data);
      reg_access(1'b0, addr, 32'd0, data);
   endtask

   task automatic register_test();
      logic [7:0]  addrs [9];
      logic [31:0] masks [9];
      logic [31:0] val;
      logic [31:0] rd;
      addrs = '{pktgen_pkg::ADDR_MACSA0, pktgen_pkg::ADDR_MACSA1, pktgen_pkg::ADDR_MACDA0,
                pktgen_pkg::ADDR_MACDA1, pktgen_pkg::ADDR_NUMPKTS, pktgen_pkg::ADDR_PKTLENGTH,
                pktgen_pkg::ADDR_RNDSEED0, pktgen_pkg::ADDR_RNDSEED1,
                pktgen_pkg::ADDR_RNDSEED2};
      masks = '{32'hffffffff, 32'h0000ffff, 32'hffffffff, 32'h0000ffff, 32'hffffffff,
                32'h0000ffff, 32'h007fffff, 32'h007fffff, 32'h007fffff};
      for (int k = 0; k < 9; k++) begin
         val = 32'h9e37_79b9 ^ (32'(k) * 32'h0101_0101);  // distinct per register
         reg_write(addrs[k], val);
         reg_read(addrs[k], rd);
         if (rd !== (val & masks[k])) report_mismatch("register readback", 64'(rd),
                                                      64'(val & masks[k]));
      end
      reg_write(8'h20, 32'hffff_ffff);  // no register there
      reg_read(8'h20, rd);
      if (rd !== 32'd0) report_mismatch("unused address 0x20", 64'(rd), 64'd0);
      reg_read(8'h01, rd);
      if (rd !== 32'd0) report_mismatch("unused address 0x01", 64'(rd), 64'd0);
   endtask

   // ------------------------------
   // stream monitor
   // ------------------------------
   task automatic check_beat();
      int          nbeats;
      int          j;
      logic        exp_eop;
      logic [2:0]  exp_empty;
      logic [63:0] exp_w;
      logic [63:0] mask;
      nbeats    = (int'(exp_len) + 7) / 8;
      j         = beat_idx - 2;  // payload beat number
      exp_eop   = (j == nbeats - 1);
      exp_empty = exp_eop ? 3'((8 - int'(exp_len) % 8) % 8) : 3'd0;
      if (tx_sop !== (beat_idx == 0)) report_mismatch("sop", 64'(tx_sop), 64'(beat_idx == 0));
      if (tx_eop !== exp_eop) report_mismatch("eop", 64'(tx_eop), 64'(exp_eop));
      if (tx_empty !== exp_empty) report_mismatch("empty", 64'(tx_empty), 64'(exp_empty));
      if (beat_idx == 0) begin
         exp_w = {exp_da, exp_sa[47:32]};
         if (tx_data !== exp_w) report_mismatch("header beat 0", tx_data, exp_w);
      end else if (beat_idx == 1) begin
         exp_w = {exp_sa[31:0], exp_len, 16'(frames_seen)};  // seq counts from 0
         if (tx_data !== exp_w) report_mismatch("header beat 1", tx_data, exp_w);
      end else if (exp_rnd) begin
         if (frames_seen == 0 && j == 0 && tx_data !== exp_first)
            report_mismatch("first prbs beat", tx_data, exp_first);
         rnd_q.push_back(tx_data);
      end else begin
         exp_w = '0;
         mask  = '0;
         for (int k = 0; k < 8; k++) begin
            if (8 * j + k < int'(exp_len)) begin  // only bytes inside the payload
               exp_w[63-8*k -: 8] = 8'((8 * j + k) % 256);
               mask[63-8*k -: 8]  = 8'hff;
            end
         end
         if ((tx_data & mask) !== exp_w) report_mismatch("payload beat", tx_data & mask, exp_w);
      end
      if (exp_eop) begin
         beat_idx = 0;
         frames_seen++;
      end else begin
         beat_idx++;
      end
   endtask

   // a stalled beat must stay put until it is taken
   always @(negedge clk) begin
      if (!reset && stalled && {tx_valid, tx_sop, tx_eop, tx_empty, tx_data} !== stall_beat)
         report_mismatch("stream outputs under back-pressure", tx_data, stall_beat[63:0]);
      stalled    = !reset && tx_valid && !tx_ready;
      stall_beat = {tx_valid, tx_sop, tx_eop, tx_empty, tx_data};
      if (!reset && tx_valid && tx_ready) check_beat();  // beat moves on the next edge
   end

   function automatic bit payloads_match();
      if (rnd_q.size() != rnd_ref.size()) return 1'b0;
      foreach (rnd_q[k]) begin
         if (rnd_q[k] !== rnd_ref[k]) return 1'b0;
      end
      return 1'b1;
   endfunction

   // ------------------------------
   // waits and runs
   // ------------------------------
   task automatic wait_frames(input int n);
      int guard;
      guard = 0;
      while (frames_seen < n && guard < WAIT_LIMIT) begin
         @(posedge clk);
         guard++;
      end
      if (frames_seen < n) abort_run("timeout waiting for frames on the stream");
      @(posedge clk);
      #1;
   endtask

   // with stop set only a stopped FSM leaves valid low two cycles running
   task automatic wait_idle();
      int lows;
      int guard;
      lows  = 0;
      guard = 0;
      while (lows < 2 && guard < WAIT_LIMIT) begin
         @(negedge clk);
         if (tx_valid) lows = 0;
         else lows++;
         guard++;
      end
      if (lows < 2) abort_run("timeout waiting for the stream to stop");
      @(posedge clk);
      #1;
   endtask

   task automatic quiet_window();
      int busy;
      busy = 0;
      repeat (QUIET) begin
         @(negedge clk);
         if (tx_valid) busy++;
      end
      if (busy != 0) report_mismatch("valid cycles after run end", 64'(busy), 64'd0);
      @(posedge clk);
      #1;
   endtask

   task automatic set_cfg(input int i, input logic [31:0] len, input logic [31:0] cnt,
                          input logic rnd, input logic [2:0][22:0] seeds, input int cmp);
      cfg_da[i]   = {24'h02a1b2, 8'(i), 16'hd0d0};
      cfg_sa[i]   = {24'h0c1d2e, 8'(i), 16'h5a5a};
      cfg_len[i]  = len;
      cfg_cnt[i]  = cnt;
      cfg_rnd[i]  = rnd;
      cfg_seed[i] = seeds;
      cfg_cmp[i]  = cmp;
   endtask

   task automatic load_table();
      logic [2:0][22:0] sa;
      logic [2:0][22:0] sb;
      sa = {23'h3c3c3c, 23'h0f00d1, 23'h1abcde};
      sb = {23'h0abcde, 23'h2468ac, 23'h123456};
      set_cfg(0, 32'd8, 32'd2, 1'b0, sa, 0);
      set_cfg(1, 32'd13, 32'd3, 1'b0, sa, 0);
      set_cfg(2, 32'd64, 32'd2, 1'b0, sa, 0);
      set_cfg(3, 32'd1499, 32'd2, 1'b0, sa, 0);
      set_cfg(4, 32'd3, 32'd1, 1'b0, sa, 0);     // clamps up to 8
      set_cfg(5, 32'd4000, 32'd1, 1'b0, sa, 0);  // clamps down to 1500
      set_cfg(6, 32'd100, 32'd3, 1'b1, sa, 1);
      set_cfg(7, 32'd100, 32'd3, 1'b1, sa, 2);
      set_cfg(8, 32'd100, 32'd3, 1'b1, sb, 3);
      set_cfg(9, 32'd40, 32'd0, 1'b0, sa, 0);    // endless run ended by stop
   endtask

   task automatic run_cfg(input int i);
      logic [31:0] rd;
      int          exp_frames;
      int          at_stop;
      reg_write(pktgen_pkg::ADDR_STOP, 32'd0);
      reg_write(pktgen_pkg::ADDR_MACDA0, cfg_da[i][31:0]);
      reg_write(pktgen_pkg::ADDR_MACDA1, {16'd0, cfg_da[i][47:32]});
      reg_write(pktgen_pkg::ADDR_MACSA0, cfg_sa[i][31:0]);
      reg_write(pktgen_pkg::ADDR_MACSA1, {16'd0, cfg_sa[i][47:32]});
      reg_write(pktgen_pkg::ADDR_PKTLENGTH, cfg_len[i]);
      reg_write(pktgen_pkg::ADDR_NUMPKTS, cfg_cnt[i]);
      reg_write(pktgen_pkg::ADDR_RANDOMPAYLOAD, {31'd0, cfg_rnd[i]});
      reg_write(pktgen_pkg::ADDR_RNDSEED0, {9'd0, cfg_seed[i][0]});
      reg_write(pktgen_pkg::ADDR_RNDSEED1, {9'd0, cfg_seed[i][1]});
      reg_write(pktgen_pkg::ADDR_RNDSEED2, {9'd0, cfg_seed[i][2]});
      exp_da      = cfg_da[i];
      exp_sa      = cfg_sa[i];
      exp_len     = clamp_len(cfg_len[i]);
      exp_rnd     = cfg_rnd[i];
      exp_first   = 64'({cfg_seed[i][2], cfg_seed[i][1], cfg_seed[i][0]});  // lane 2 highest
      beat_idx    = 0;
      frames_seen = 0;
      rnd_q.delete();
      reg_write(pktgen_pkg::ADDR_START, 32'd1);
      if (cfg_cnt[i] == 32'd0) begin
         wait_frames(2);
         at_stop = frames_seen;
         reg_write(pktgen_pkg::ADDR_STOP, 32'd1);
         wait_idle();
         exp_frames = frames_seen;
         if (frames_seen > at_stop + 1) report_mismatch("frames after stop",
                                                        64'(frames_seen - at_stop), 64'd1);
      end else begin
         wait_frames(int'(cfg_cnt[i]));
         exp_frames = int'(cfg_cnt[i]);
      end
      quiet_window();
      if (frames_seen != exp_frames) report_mismatch("frame count", 64'(frames_seen),
                                                     64'(exp_frames));
      if (beat_idx != 0) report_mismatch("beats of unfinished frame", 64'(beat_idx), 64'd0);
      reg_read(pktgen_pkg::ADDR_TXPKTCNT, rd);
      if (rd !== 32'(exp_frames)) report_mismatch("TXPKTCNT", 64'(rd), 64'(exp_frames));
      case (cfg_cmp[i])
         1: rnd_ref = rnd_q;
         2: if (!payloads_match()) report_mismatch("payload equal to reference", 64'd0, 64'd1);
         3: if (payloads_match()) report_mismatch("payload equal to reference", 64'd1, 64'd0);
         default: ;
      endcase
   endtask

   // ------------------------------
   // main sequence
   // ------------------------------
   initial begin
      reset       = 1'b1;
      read        = 1'b0;
      write       = 1'b0;
      address     = '0;
      writedata   = '0;
      err_cnt     = 0;
      timeout_cnt = 0;
      beat_idx    = 0;
      frames_seen = 0;
      stalled     = 1'b0;
      exp_da      = '0;
      exp_sa      = '0;
      exp_len     = 16'd8;
      exp_rnd     = 1'b0;
      exp_first   = '0;
      load_table();
      repeat (3) @(posedge clk);
      #1;
      reset = 1'b0;
      @(posedge clk);
      #1;
      if ({tx_valid, tx_sop, tx_eop, waitrequest} !== 4'b0000)
         report_mismatch("outputs after reset", 64'({tx_valid, tx_sop, tx_eop, waitrequest}),
                         64'd0);
      register_test();
      for (int i = 0; i < N_CFG; i++) begin
         run_cfg(i);
      end
      $display("errors: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
      if (err_cnt == 0 && timeout_cnt == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// ==== verilog/pktgen_top.sv ====
// stream has no fcs and the host port needs a one-cycle gap between accesses
module pktgen_top (
   input  logic                           clk,
   input  logic                           reset,
   input  logic [pktgen_pkg::ADDR_W-1:0]  address,
   input  logic                           read,
   input  logic                           write,
   input  logic [pktgen_pkg::DATA_W-1:0]  writedata,
   output logic [pktgen_pkg::DATA_W-1:0]  readdata,
   output logic                           waitrequest,
   input  logic                           tx_ready,
   output logic [pktgen_pkg::BEAT_W-1:0]  tx_data,
   output logic                           tx_valid,
   output logic                           tx_sop,
   output logic                           tx_eop,
   output logic [pktgen_pkg::EMPTY_W-1:0] tx_empty
);

   logic                          start_pulse;
   logic                          stop;
   logic [pktgen_pkg::DATA_W-1:0] num_frames;
   pktgen_pkg::payload_mode_t     payload_mode;
   logic [47:0]                   dest_mac;
   logic [47:0]                   src_mac;
   logic [pktgen_pkg::LEN_W-1:0]  pkt_len;
   logic [pktgen_pkg::PRBS_W-1:0] seed0;
   logic [pktgen_pkg::PRBS_W-1:0] seed1;
   logic [pktgen_pkg::PRBS_W-1:0] seed2;
   logic [pktgen_pkg::BEAT_W-1:0] payload_word;
   logic                          payload_adv;
   logic                          frame_sent;
   logic                          frame_start;

   pktgen_regs u_regs (
      .clk(clk), .reset(reset), .address(address), .read(read), .write(write),
      .writedata(writedata), .frame_sent(frame_sent), .readdata(readdata),
      .waitrequest(waitrequest), .start_pulse(start_pulse), .stop(stop),
      .num_frames(num_frames), .payload_mode(payload_mode), .dest_mac(dest_mac),
      .src_mac(src_mac), .pkt_len(pkt_len), .seed0(seed0), .seed1(seed1), .seed2(seed2)
   );

   payload_src u_src (
      .clk(clk), .reset(reset), .start_pulse(start_pulse), .frame_start(frame_start),
      .payload_adv(payload_adv), .payload_mode(payload_mode), .seed0(seed0),
      .seed1(seed1), .seed2(seed2), .payload_word(payload_word)
   );

   frame_fsm u_fsm (
      .clk(clk), .reset(reset), .start_pulse(start_pulse), .stop(stop),
      .num_frames(num_frames), .dest_mac(dest_mac), .src_mac(src_mac), .pkt_len(pkt_len),
      .payload_word(payload_word), .tx_ready(tx_ready), .tx_data(tx_data),
      .tx_valid(tx_valid), .tx_sop(tx_sop), .tx_eop(tx_eop), .tx_empty(tx_empty),
      .payload_adv(payload_adv), .frame_sent(frame_sent), .frame_start(frame_start)
   );

endmodule

// ==== verilog/frame_fsm.sv ====
// one frame in flight and the clamped length is sampled again at each sop beat
module frame_fsm (
   input  logic                           clk,
   input  logic                           reset,
   input  logic                           start_pulse,
   input  logic                           stop,
   input  logic [pktgen_pkg::DATA_W-1:0]  num_frames,   // 0 runs until stop
   input  logic [47:0]                    dest_mac,
   input  logic [47:0]                    src_mac,
   input  logic [pktgen_pkg::LEN_W-1:0]   pkt_len,
   input  logic [pktgen_pkg::BEAT_W-1:0]  payload_word,
   input  logic                           tx_ready,
   output logic [pktgen_pkg::BEAT_W-1:0]  tx_data,
   output logic                           tx_valid,
   output logic                           tx_sop,
   output logic                           tx_eop,
   output logic [pktgen_pkg::EMPTY_W-1:0] tx_empty,
   output logic                           payload_adv,  // payload word taken
   output logic                           frame_sent,   // sop beat accepted
   output logic                           frame_start   // sop beat loaded
);

   pktgen_pkg::gen_state_t         state;
   logic                           xfer;
   logic                           run_done;
   logic                           last_beat;
   logic [pktgen_pkg::EMPTY_W-1:0] empty_nxt;
   logic [pktgen_pkg::LEN_W-1:0]   len_q;      // length of the frame in flight
   logic [pktgen_pkg::LEN_W-1:0]   remain;     // payload bytes not yet loaded
   logic [pktgen_pkg::LEN_W-1:0]   seq;
   logic [pktgen_pkg::DATA_W-1:0]  frame_cnt;  // frames done in this run

   assign xfer      = tx_valid & tx_ready;
   assign run_done  = stop | ((num_frames != '0) & (frame_cnt == num_frames));
   assign last_beat = remain <= 16'd8;
   assign empty_nxt = ~remain[pktgen_pkg::EMPTY_W-1:0] + 1'b1;  // (8 - L mod 8) mod 8

   // ------------------------------
   // beat load strobes
   // ------------------------------
   assign frame_start = ((state == pktgen_pkg::ST_IDLE) & start_pulse) |
                        ((state == pktgen_pkg::ST_GAP) & ~run_done);
   assign frame_sent  = xfer & (state == pktgen_pkg::ST_DEST_SRC);
   assign payload_adv = xfer & ((state == pktgen_pkg::ST_SRC_LEN_SEQ) |
                                ((state == pktgen_pkg::ST_DATA) & ~tx_eop));

   // control state, outputs only move on a transfer or while valid is low
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         state     <= pktgen_pkg::ST_IDLE;
         tx_valid  <= 1'b0;
         tx_sop    <= 1'b0;
         tx_eop    <= 1'b0;
         tx_empty  <= '0;
         len_q     <= '0;
         remain    <= '0;
         seq       <= '0;
         frame_cnt <= '0;
      end else if (frame_start) begin
         state    <= pktgen_pkg::ST_DEST_SRC;
         tx_valid <= 1'b1;
         tx_sop   <= 1'b1;
         len_q    <= pkt_len;
         if (state == pktgen_pkg::ST_IDLE) begin  // new run
            seq       <= '0;
            frame_cnt <= '0;
         end
      end else if (frame_sent) begin
         state  <= pktgen_pkg::ST_SRC_LEN_SEQ;
         tx_sop <= 1'b0;
         remain <= len_q;
      end else if (payload_adv) begin
         state    <= pktgen_pkg::ST_DATA;
         tx_eop   <= last_beat;
         tx_empty <= last_beat ? empty_nxt : '0;
         remain   <= remain - 16'd8;
      end else if (xfer & (state == pktgen_pkg::ST_DATA)) begin
         // eop beat gone
         state     <= pktgen_pkg::ST_GAP;
         tx_valid  <= 1'b0;
         tx_eop    <= 1'b0;
         tx_empty  <= '0;
         seq       <= seq + 1'b1;
         frame_cnt <= frame_cnt + 1'b1;
      end else if (state == pktgen_pkg::ST_GAP) begin
         state <= pktgen_pkg::ST_IDLE;  // run over
      end
   end

   // beat data
   always_ff @(posedge clk) begin
      if (frame_start) tx_data <= {dest_mac, src_mac[47:32]};
      else if (frame_sent) tx_data <= {src_mac[31:0], len_q, seq};
      else if (payload_adv) tx_data <= payload_word;
   end

endmodule

// ==== verilog/payload_src.sv ====
// prbs lanes restart only at START so frames of one run continue the same random streams
module payload_src (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          start_pulse,
   input  logic                          frame_start,   // sop beat loaded
   input  logic                          payload_adv,   // current word taken
   input  pktgen_pkg::payload_mode_t     payload_mode,
   input  logic [pktgen_pkg::PRBS_W-1:0] seed0,
   input  logic [pktgen_pkg::PRBS_W-1:0] seed1,
   input  logic [pktgen_pkg::PRBS_W-1:0] seed2,
   output logic [pktgen_pkg::BEAT_W-1:0] payload_word
);

   logic [7:0]                      byte_cnt;   // first byte of the word on offer
   logic [pktgen_pkg::BEAT_W-1:0]   incr_word;
   logic [pktgen_pkg::PRBS_W-1:0]   lane0;
   logic [pktgen_pkg::PRBS_W-1:0]   lane1;
   logic [pktgen_pkg::PRBS_W-1:0]   lane2;
   logic [3*pktgen_pkg::PRBS_W-1:0] lanes;

   // byte counter wraps mod 256
   always_ff @(posedge clk or posedge reset) begin
      if (reset) byte_cnt <= '0;
      else if (frame_start) byte_cnt <= '0;
      else if (payload_adv) byte_cnt <= byte_cnt + 8'd8;
   end

   // byte 0 goes in the top lane of the beat
   always_comb begin
      for (int k = 0; k < 8; k++) begin
         incr_word[pktgen_pkg::BEAT_W-1-8*k -: 8] = byte_cnt + 8'(k);
      end
   end

   prbs23 u_lane0 (.clk(clk), .reset(reset), .load(start_pulse), .enable(payload_adv),
                   .seed(seed0), .lane(lane0));
   prbs23 u_lane1 (.clk(clk), .reset(reset), .load(start_pulse), .enable(payload_adv),
                   .seed(seed1), .lane(lane1));
   prbs23 u_lane2 (.clk(clk), .reset(reset), .load(start_pulse), .enable(payload_adv),
                   .seed(seed2), .lane(lane2));

   assign lanes = {lane2, lane1, lane0};  // lane 2 highest, top 5 bits dropped

   assign payload_word = (payload_mode == pktgen_pkg::PL_RANDOM) ?
                         lanes[pktgen_pkg::BEAT_W-1:0] : incr_word;

endmodule

// ==== verilog/prbs23.sv ====
// lane holds zero after reset and produces nothing useful until loaded with a nonzero seed
module prbs23 (
   input  logic                          clk,
   input  logic                          reset,
   input  logic                          load,    // take the seed
   input  logic                          enable,  // advance one whole lane
   input  logic [pktgen_pkg::PRBS_W-1:0] seed,
   output logic [pktgen_pkg::PRBS_W-1:0] lane
);

   logic [pktgen_pkg::PRBS_W-1:0] lane_nxt;

   // x^23 + x^18 + 1, 23 serial shifts unrolled into one cycle
   always_comb begin
      lane_nxt = lane;
      for (int i = 0; i < pktgen_pkg::PRBS_W; i++) begin
         lane_nxt = {lane_nxt[18] ^ lane_nxt[0], lane_nxt[pktgen_pkg::PRBS_W-1:1]};
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         lane <= '0;
      end else if (load) begin
         lane <= seed;
      end else if (enable) begin
         lane <= lane_nxt;
      end
   end

endmodule

// ==== verilog/pktgen_regs.sv ====
// host must drop read and write for a cycle between accesses or waitrequest is not raised again
module pktgen_regs (
   input  logic                          clk,
   input  logic                          reset,
   input  logic [pktgen_pkg::ADDR_W-1:0] address,
   input  logic                          read,
   input  logic                          write,
   input  logic [pktgen_pkg::DATA_W-1:0] writedata,
   input  logic                          frame_sent,    // sop beat accepted
   output logic [pktgen_pkg::DATA_W-1:0] readdata,
   output logic                          waitrequest,
   output logic                          start_pulse,
   output logic                          stop,
   output logic [pktgen_pkg::DATA_W-1:0] num_frames,
   output pktgen_pkg::payload_mode_t     payload_mode,
   output logic [47:0]                   dest_mac,
   output logic [47:0]                   src_mac,
   output logic [pktgen_pkg::LEN_W-1:0]  pkt_len,       // clamped
   output logic [pktgen_pkg::PRBS_W-1:0] seed0,
   output logic [pktgen_pkg::PRBS_W-1:0] seed1,
   output logic [pktgen_pkg::PRBS_W-1:0] seed2
);

   logic                          rd_d;
   logic                          wr_d;
   logic                          rd_edge;
   logic                          wr_edge;
   logic                          start_reg;
   logic                          start_d;
   logic [31:0]                   macsa0;
   logic [15:0]                   macsa1;
   logic [31:0]                   macda0;
   logic [15:0]                   macda1;
   logic [pktgen_pkg::LEN_W-1:0]  len_reg;   // raw PKTLENGTH
   logic [pktgen_pkg::DATA_W-1:0] tx_cnt;

   // ------------------------------
   // access handshake
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         rd_d <= 1'b0;
         wr_d <= 1'b0;
      end else begin
         rd_d <= read;
         wr_d <= write;
      end
   end

   assign rd_edge     = read & ~rd_d;       // first cycle of a read
   assign wr_edge     = write & ~wr_d;
   assign waitrequest = rd_edge | wr_edge;  // low again in the second cycle

   // ------------------------------
   // register writes
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         num_frames   <= '0;
         payload_mode <= pktgen_pkg::PL_INCR;
         start_reg    <= 1'b0;
         stop         <= 1'b0;
         macsa0       <= '0;
         macsa1       <= '0;
         macda0       <= '0;
         macda1       <= '0;
         len_reg      <= '0;
         seed0        <= pktgen_pkg::SEED_RST0;
         seed1        <= pktgen_pkg::SEED_RST1;
         seed2        <= pktgen_pkg::SEED_RST2;
      end else begin
         start_reg <= 1'b0;  // clears itself
         if (wr_edge) begin
            case (address)
               pktgen_pkg::ADDR_NUMPKTS:       num_frames <= writedata;
               pktgen_pkg::ADDR_RANDOMPAYLOAD:
                  payload_mode <= pktgen_pkg::payload_mode_t'(writedata[0]);
               pktgen_pkg::ADDR_START:         start_reg <= writedata[0];
               pktgen_pkg::ADDR_STOP:          stop <= writedata[0];
               pktgen_pkg::ADDR_MACSA0:        macsa0 <= writedata;
               pktgen_pkg::ADDR_MACSA1:        macsa1 <= writedata[15:0];
               pktgen_pkg::ADDR_MACDA0:        macda0 <= writedata;
               pktgen_pkg::ADDR_MACDA1:        macda1 <= writedata[15:0];
               pktgen_pkg::ADDR_RNDSEED0:      seed0 <= writedata[pktgen_pkg::PRBS_W-1:0];
               pktgen_pkg::ADDR_RNDSEED1:      seed1 <= writedata[pktgen_pkg::PRBS_W-1:0];
               pktgen_pkg::ADDR_RNDSEED2:      seed2 <= writedata[pktgen_pkg::PRBS_W-1:0];
               pktgen_pkg::ADDR_PKTLENGTH:     len_reg <= writedata[pktgen_pkg::LEN_W-1:0];
               default: ;                      // read only or unused
            endcase
         end
      end
   end

   // start edge into a single cycle pulse
   always_ff @(posedge clk or posedge reset) begin
      if (reset) start_d <= 1'b0;
      else start_d <= start_reg;
   end

   assign start_pulse = start_reg & ~start_d;

   // frames sent since the last start
   always_ff @(posedge clk or posedge reset) begin
      if (reset) tx_cnt <= '0;
      else if (start_pulse) tx_cnt <= '0;
      else if (frame_sent) tx_cnt <= tx_cnt + 1'b1;
   end

   assign dest_mac = {macda1, macda0};
   assign src_mac  = {macsa1, macsa0};

   always_comb begin
      if (len_reg < pktgen_pkg::MIN_PAYLOAD) pkt_len = pktgen_pkg::MIN_PAYLOAD;
      else if (len_reg > pktgen_pkg::MAX_PAYLOAD) pkt_len = pktgen_pkg::MAX_PAYLOAD;
      else pkt_len = len_reg;
   end

   // ------------------------------
   // read mux, sampled in the first cycle
   // ------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         readdata <= '0;
      end else if (rd_edge) begin
         case (address)
            pktgen_pkg::ADDR_NUMPKTS:       readdata <= num_frames;
            pktgen_pkg::ADDR_RANDOMPAYLOAD: readdata <= {31'd0, payload_mode};
            pktgen_pkg::ADDR_START:         readdata <= {31'd0, start_reg};
            pktgen_pkg::ADDR_STOP:          readdata <= {31'd0, stop};
            pktgen_pkg::ADDR_MACSA0:        readdata <= macsa0;
            pktgen_pkg::ADDR_MACSA1:        readdata <= {16'd0, macsa1};
            pktgen_pkg::ADDR_MACDA0:        readdata <= macda0;
            pktgen_pkg::ADDR_MACDA1:        readdata <= {16'd0, macda1};
            pktgen_pkg::ADDR_TXPKTCNT:      readdata <= tx_cnt;
            pktgen_pkg::ADDR_RNDSEED0:      readdata <= {9'd0, seed0};
            pktgen_pkg::ADDR_RNDSEED1:      readdata <= {9'd0, seed1};
            pktgen_pkg::ADDR_RNDSEED2:      readdata <= {9'd0, seed2};
            pktgen_pkg::ADDR_PKTLENGTH:     readdata <= {16'd0, len_reg};
            default:                        readdata <= '0;
         endcase
      end
   end

endmodule

// ==== verilog/pktgen_pkg.sv ====
// payload lengths outside 8 to 1500 bytes are clamped and seeds must be nonzero for prbs output
package pktgen_pkg;

   // ------------------------------
   // widths
   // ------------------------------
   localparam int ADDR_W  = 8;   // register address
   localparam int DATA_W  = 32;  // register data
   localparam int BEAT_W  = 64;  // stream beat
   localparam int EMPTY_W = 3;   // unused bytes on eop
   localparam int LEN_W   = 16;  // payload length and sequence number
   localparam int PRBS_W  = 23;  // one prbs lane

   // ------------------------------
   // register map
   // ------------------------------
   localparam logic [ADDR_W-1:0] ADDR_NUMPKTS       = 8'h00;  // frames per run (0 is endless)
   localparam logic [ADDR_W-1:0] ADDR_RANDOMPAYLOAD = 8'h02;  // bit 0 selects prbs payload
   localparam logic [ADDR_W-1:0] ADDR_START         = 8'h03;  // self clearing
   localparam logic [ADDR_W-1:0] ADDR_STOP          = 8'h04;
   localparam logic [ADDR_W-1:0] ADDR_MACSA0        = 8'h05;  // source mac bits 31:0
   localparam logic [ADDR_W-1:0] ADDR_MACSA1        = 8'h06;  // source mac bits 47:32
   localparam logic [ADDR_W-1:0] ADDR_MACDA0        = 8'h07;
   localparam logic [ADDR_W-1:0] ADDR_MACDA1        = 8'h08;
   localparam logic [ADDR_W-1:0] ADDR_TXPKTCNT      = 8'h09;  // read only
   localparam logic [ADDR_W-1:0] ADDR_RNDSEED0      = 8'h0a;
   localparam logic [ADDR_W-1:0] ADDR_RNDSEED1      = 8'h0b;
   localparam logic [ADDR_W-1:0] ADDR_RNDSEED2      = 8'h0c;
   localparam logic [ADDR_W-1:0] ADDR_PKTLENGTH     = 8'h0d;  // payload bytes before clamp

   // clamp limits in payload bytes
   localparam logic [LEN_W-1:0] MIN_PAYLOAD = 16'd8;
   localparam logic [LEN_W-1:0] MAX_PAYLOAD = 16'd1500;

   // nonzero seed values out of reset
   localparam logic [PRBS_W-1:0] SEED_RST0 = 23'h5eed00;
   localparam logic [PRBS_W-1:0] SEED_RST1 = 23'h5eed01;
   localparam logic [PRBS_W-1:0] SEED_RST2 = 23'h025eed;

   typedef enum logic [2:0] {
      ST_IDLE,         // waiting for start
      ST_DEST_SRC,     // beat 0 on the bus
      ST_SRC_LEN_SEQ,  // beat 1 on the bus
      ST_DATA,         // payload beats
      ST_GAP           // one idle cycle between frames
   } gen_state_t;

   typedef enum logic {
      PL_INCR   = 1'b0,  // byte i is i mod 256
      PL_RANDOM = 1'b1   // three prbs lanes
   } payload_mode_t;

endpackage
